// File: logic/idr_pkg.sv
package idr_pkg;

  // ---------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------
  localparam int ID_UP_W    = 7;   // Upstream master ID
  localparam int ID_DN_W    = 6;   // Downstream ID after remap
  localparam int ADDR_UP_W  = 64;
  localparam int ADDR_DN_W  = 49;  // Physical address bits on the port
  localparam int USER_UP_W  = 4;
  localparam int DATA_W     = 128;
  localparam int LEN_W      = 8;
  localparam int SIZE_W     = 3;
  localparam int PROT_W     = 3;
  localparam int RESP_W     = 2;

  // ---------------------------------------------------------------------
  // Remap table
  // ---------------------------------------------------------------------
  localparam int TABLE_SIZE = 16;
  localparam int IDX_W      = 4;   // Entry index, becomes the downstream ID
  localparam int CNT_W      = 4;
  localparam int CNT_MAX    = (1 << CNT_W) - 1;  // Bursts in flight per entry

  // Forced on every downstream request
  localparam logic [PROT_W-1:0] PROT_FIXED = 3'b010;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // ---------------------------------------------------------------------
  // Channel payloads
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [ID_UP_W-1:0]   id;
    logic [ADDR_UP_W-1:0] addr;
    logic [LEN_W-1:0]     len;
    logic [SIZE_W-1:0]    size;
    burst_e               burst;
    logic [PROT_W-1:0]    prot;
    logic [USER_UP_W-1:0] user;
  } ar_up_t;

  typedef struct packed {
    logic [ID_DN_W-1:0]   id;
    logic [ADDR_DN_W-1:0] addr;
    logic [LEN_W-1:0]     len;
    logic [SIZE_W-1:0]    size;
    burst_e               burst;
    logic [PROT_W-1:0]    prot;
    logic                 user;   // Only bit 0 survives downstream
  } ar_dn_t;

  typedef struct packed {
    logic [ID_DN_W-1:0]   id;
    logic [DATA_W-1:0]    data;
    logic [RESP_W-1:0]    resp;
    logic                 last;
  } r_dn_t;

  typedef struct packed {
    logic [ID_UP_W-1:0]   id;
    logic [DATA_W-1:0]    data;
    logic [RESP_W-1:0]    resp;
    logic                 last;
  } r_up_t;

endpackage

// File: logic/id_remap_table.sv
`timescale 1ns/10ps

module id_remap_table (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Request side
  input  logic                        req_valid_i,
  input  logic [idr_pkg::ID_UP_W-1:0] req_id_i,
  input  logic                        req_fire_i,
  output logic                        grant_o,
  output logic [idr_pkg::IDX_W-1:0]   grant_idx_o,
  // Return side
  input  logic [idr_pkg::IDX_W-1:0]   rsp_idx_i,
  input  logic                        rsp_done_i,
  output logic [idr_pkg::ID_UP_W-1:0] rsp_id_o
);

  logic [idr_pkg::ID_UP_W-1:0]   id_q  [idr_pkg::TABLE_SIZE];
  logic [idr_pkg::CNT_W-1:0]     cnt_q [idr_pkg::TABLE_SIZE];

  logic [idr_pkg::TABLE_SIZE-1:0] busy;
  logic [idr_pkg::TABLE_SIZE-1:0] inc;
  logic [idr_pkg::TABLE_SIZE-1:0] dec;

  logic                         match_found;
  logic [idr_pkg::IDX_W-1:0]    match_idx;
  logic                         free_found;
  logic [idr_pkg::IDX_W-1:0]    free_idx;
  logic                         match_room;

  // ---------------------------------------------------------------------
  // Lookup
  // ---------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
      busy[i] = (cnt_q[i] != '0);
    end
  end

  // A busy entry holds a unique upstream ID, so at most one can match
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
      if (busy[i] && (id_q[i] == req_id_i)) begin
        match_found = 1'b1;
        match_idx   = idr_pkg::IDX_W'(i);
      end
    end
  end

  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = idr_pkg::TABLE_SIZE - 1; i >= 0; i--) begin  // Lowest index wins
      if (!busy[i]) begin
        free_found = 1'b1;
        free_idx   = idr_pkg::IDX_W'(i);
      end
    end
  end

  assign match_room = (cnt_q[match_idx] < idr_pkg::CNT_W'(idr_pkg::CNT_MAX));

  // Same ID never opens a second entry, that keeps its bursts in order
  always_comb begin
    if (!req_valid_i) begin
      grant_o = 1'b1;  // Idle upstream keeps ready high
    end else if (match_found) begin
      grant_o = match_room;
    end else begin
      grant_o = free_found;
    end
  end

  assign grant_idx_o = match_found ? match_idx : free_idx;

  // ---------------------------------------------------------------------
  // Counter update
  // ---------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
      inc[i] = req_fire_i && (grant_idx_o == idr_pkg::IDX_W'(i));
      dec[i] = rsp_done_i && (rsp_idx_i == idr_pkg::IDX_W'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
        if (inc[i] && !dec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (dec[i] && !inc[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;  // Reaching zero frees the entry
        end
      end
    end
  end

  // Rewriting a matched entry stores the same ID again
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
      if (inc[i]) begin
        id_q[i] <= req_id_i;
      end
    end
  end

  // ---------------------------------------------------------------------
  // ID restore for returning data
  // ---------------------------------------------------------------------
  assign rsp_id_o = id_q[rsp_idx_i];

endmodule

// File: logic/ar_slice.sv
`timescale 1ns/10ps

module ar_slice (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Upstream AR
  input  idr_pkg::ar_up_t             ar_up_i,
  input  logic                        ar_up_valid_i,
  output logic                        ar_up_ready_o,
  // Remap table
  output logic                        req_valid_o,
  output logic [idr_pkg::ID_UP_W-1:0] req_id_o,
  output logic                        req_fire_o,
  input  logic                        grant_i,
  input  logic [idr_pkg::IDX_W-1:0]   grant_idx_i,
  // Downstream AR
  output idr_pkg::ar_dn_t             ar_dn_o,
  output logic                        ar_dn_valid_o,
  input  logic                        ar_dn_ready_i
);

  logic            full_q;
  logic            can_load;
  idr_pkg::ar_dn_t beat_d;
  idr_pkg::ar_dn_t beat_q;

  // ---------------------------------------------------------------------
  // Handshake
  // ---------------------------------------------------------------------
  assign can_load      = !full_q || ar_dn_ready_i;  // Empty or emptying now
  assign ar_up_ready_o = can_load && grant_i;
  assign req_fire_o    = ar_up_valid_i && ar_up_ready_o;

  assign req_valid_o   = ar_up_valid_i;
  assign req_id_o      = ar_up_i.id;

  // ---------------------------------------------------------------------
  // Conversion to the downstream form
  // ---------------------------------------------------------------------
  always_comb begin
    beat_d.id    = {{(idr_pkg::ID_DN_W - idr_pkg::IDX_W){1'b0}}, grant_idx_i};
    beat_d.addr  = ar_up_i.addr[idr_pkg::ADDR_DN_W-1:0];
    beat_d.len   = ar_up_i.len;
    beat_d.size  = ar_up_i.size;
    beat_d.burst = ar_up_i.burst;
    beat_d.prot  = idr_pkg::PROT_FIXED;  // Upstream prot is ignored
    beat_d.user  = ar_up_i.user[0];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (req_fire_o) begin
      full_q <= 1'b1;
    end else if (ar_dn_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire_o) begin
      beat_q <= beat_d;
    end
  end

  assign ar_dn_o       = beat_q;
  assign ar_dn_valid_o = full_q;

endmodule

// File: logic/axi_rd_id_remap.sv
`timescale 1ns/10ps

module axi_rd_id_remap (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Upstream read channels
  input  idr_pkg::ar_up_t   ar_up_i,
  input  logic              ar_up_valid_i,
  output logic              ar_up_ready_o,
  output idr_pkg::r_up_t    r_up_o,
  output logic              r_up_valid_o,
  input  logic              r_up_ready_i,
  // Downstream read channels
  output idr_pkg::ar_dn_t   ar_dn_o,
  output logic              ar_dn_valid_o,
  input  logic              ar_dn_ready_i,
  input  idr_pkg::r_dn_t    r_dn_i,
  input  logic              r_dn_valid_i,
  output logic              r_dn_ready_o
);

  logic                        req_valid;
  logic [idr_pkg::ID_UP_W-1:0] req_id;
  logic                        req_fire;
  logic                        grant;
  logic [idr_pkg::IDX_W-1:0]   grant_idx;
  logic [idr_pkg::IDX_W-1:0]   rsp_idx;
  logic                        rsp_done;
  logic [idr_pkg::ID_UP_W-1:0] rsp_id;

  // ---------------------------------------------------------------------
  // Request path
  // ---------------------------------------------------------------------
  ar_slice u_slice (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ar_up_i        (ar_up_i),
    .ar_up_valid_i  (ar_up_valid_i),
    .ar_up_ready_o  (ar_up_ready_o),
    .req_valid_o    (req_valid),
    .req_id_o       (req_id),
    .req_fire_o     (req_fire),
    .grant_i        (grant),
    .grant_idx_i    (grant_idx),
    .ar_dn_o        (ar_dn_o),
    .ar_dn_valid_o  (ar_dn_valid_o),
    .ar_dn_ready_i  (ar_dn_ready_i)
  );

  id_remap_table u_table (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid),
    .req_id_i     (req_id),
    .req_fire_i   (req_fire),
    .grant_o      (grant),
    .grant_idx_o  (grant_idx),
    .rsp_idx_i    (rsp_idx),
    .rsp_done_i   (rsp_done),
    .rsp_id_o     (rsp_id)
  );

  // ---------------------------------------------------------------------
  // Return path, no register stage
  // ---------------------------------------------------------------------
  assign rsp_idx  = r_dn_i.id[idr_pkg::IDX_W-1:0];  // Upper ID bits are always zero
  assign rsp_done = r_dn_valid_i && r_up_ready_i && r_dn_i.last;

  assign r_up_o.id    = rsp_id;
  assign r_up_o.data  = r_dn_i.data;
  assign r_up_o.resp  = r_dn_i.resp;
  assign r_up_o.last  = r_dn_i.last;
  assign r_up_valid_o = r_dn_valid_i;
  assign r_dn_ready_o = r_up_ready_i;

endmodule

// File: sim/axi_rd_id_remap_assert.sv
`timescale 1ns/10ps

module axi_rd_id_remap_assert (
  input logic            clk_i,
  input logic            rst_n_i,
  input idr_pkg::ar_dn_t dn_beat_i,
  input logic            dn_valid_i,   // Also the slice fullness
  input logic            dn_ready_i,
  input logic            up_ready_i
);

  int fail_cnt = 0;

  // ---------------------------------------------------------------------
  // Downstream AR
  // ---------------------------------------------------------------------
  property dn_beat_stable;
    @(posedge clk_i) disable iff (!rst_n_i)
      (dn_valid_i && !dn_ready_i) |=> (dn_valid_i && $stable(dn_beat_i));
  endproperty

  property no_accept_when_stalled;
    @(posedge clk_i) disable iff (!rst_n_i)
      (dn_valid_i && !dn_ready_i) |-> !up_ready_i;
  endproperty

  property idle_after_reset;
    @(posedge clk_i) !rst_n_i |=> !dn_valid_i;
  endproperty

  a_dn_beat_stable : assert property (dn_beat_stable)
    else begin
      fail_cnt++;
      $error("Downstream AR dropped or changed while stalled");
    end

  a_no_accept_when_stalled : assert property (no_accept_when_stalled)
    else begin
      fail_cnt++;
      $error("Upstream ready high while the slice is full and stalled");
    end

  a_idle_after_reset : assert property (idle_after_reset)
    else begin
      fail_cnt++;
      $error("Downstream AR valid high right after reset");
    end

endmodule

// File: sim/tb_axi_rd_id_remap.sv
`timescale 1ns/10ps

module tb_axi_rd_id_remap;

  localparam int NUM_ROWS  = 18;
  localparam int CYCLE_MAX = 40 * NUM_ROWS + 200;
  localparam int HOLD_CYC  = 3;   // Extra cycles with downstream ready low

  typedef struct packed {
    logic [idr_pkg::ID_UP_W-1:0]   id;
    logic [idr_pkg::ADDR_UP_W-1:0] addr;
    logic [idr_pkg::USER_UP_W-1:0] user;
    logic [7:0]                    len;
    logic                          hold;
  } row_t;

  logic            clk_i;
  logic            rst_n_i;
  idr_pkg::ar_up_t ar_up_i;
  logic            ar_up_valid_i;
  logic            ar_up_ready_o;
  idr_pkg::r_up_t  r_up_o;
  logic            r_up_valid_o;
  logic            r_up_ready_i;
  idr_pkg::ar_dn_t ar_dn_o;
  logic            ar_dn_valid_o;
  logic            ar_dn_ready_i;
  idr_pkg::r_dn_t  r_dn_i;
  logic            r_dn_valid_i;
  logic            r_dn_ready_o;

  row_t                        rows      [NUM_ROWS];
  logic [idr_pkg::ID_UP_W-1:0] model_id  [idr_pkg::TABLE_SIZE];
  int                          model_cnt [idr_pkg::TABLE_SIZE];
  int                          pend_idx  [$];   // Downstream index per burst in flight
  int                          pend_len  [$];
  logic [15:0]                 lfsr_q;
  int                          err_cnt   = 0;
  int                          burst_cnt = 0;
  int                          cycle_cnt = 0;
  int                          assert_cnt;

  axi_rd_id_remap DUT (.*);

  bind axi_rd_id_remap axi_rd_id_remap_assert u_assert (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .dn_beat_i  (ar_dn_o),
    .dn_valid_i (ar_dn_valid_o),
    .dn_ready_i (ar_dn_ready_i),
    .up_ready_i (ar_up_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_MAX) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_MAX);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus table and helpers
  // ---------------------------------------------------------------------
  task automatic load_rows();
    rows[0]  = '{7'h05, 64'hFFFF_8001_2345_6789, 4'hB, 8'd3, 1'b1};  // First beat stalls
    rows[1]  = '{7'h12, 64'h0000_0000_0000_1000, 4'h2, 8'd1, 1'b0};
    rows[2]  = '{7'h05, 64'h0000_7FFF_0000_2000, 4'h4, 8'd0, 1'b0};  // Same ID as row 0
    rows[3]  = '{7'h7F, 64'hA5A5_0000_0000_3000, 4'hF, 8'd2, 1'b0};
    rows[4]  = '{7'h00, 64'h0001_0000_0000_4000, 4'h1, 8'd0, 1'b0};
    rows[5]  = '{7'h01, 64'hDEAD_BEEF_0000_5000, 4'h6, 8'd1, 1'b0};
    rows[6]  = '{7'h22, 64'h0000_0000_0000_6040, 4'h7, 8'd3, 1'b0};
    rows[7]  = '{7'h33, 64'h1234_5678_9ABC_DEF0, 4'h8, 8'd0, 1'b0};
    rows[8]  = '{7'h44, 64'h0000_FFFF_FFFF_FFF0, 4'h9, 8'd2, 1'b0};
    rows[9]  = '{7'h55, 64'h8000_0000_0000_9000, 4'hA, 8'd1, 1'b1};
    rows[10] = '{7'h66, 64'h0000_0000_0000_A000, 4'hC, 8'd0, 1'b0};
    rows[11] = '{7'h77, 64'h0F0F_0F0F_0F0F_B000, 4'hD, 8'd2, 1'b0};
    rows[12] = '{7'h08, 64'h0000_0001_0000_C000, 4'hE, 8'd1, 1'b0};
    rows[13] = '{7'h19, 64'hFFFF_FFFF_FFFF_D000, 4'h3, 8'd0, 1'b0};
    rows[14] = '{7'h2A, 64'h0000_1000_0000_E000, 4'h5, 8'd3, 1'b0};
    rows[15] = '{7'h3B, 64'h4000_0000_0000_F000, 4'h0, 8'd0, 1'b0};
    rows[16] = '{7'h4C, 64'h0000_0000_0001_0000, 4'hB, 8'd1, 1'b0};
    rows[17] = '{7'h5D, 64'hC000_0000_0002_0000, 4'h1, 8'd2, 1'b0};  // 17th distinct ID
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[b]   = lfsr_q[0];
    end
  endtask

  task automatic report_mismatch(input string name, input logic [159:0] exp,
                                 input logic [159:0] act);
    err_cnt++;
    $display("Mismatch %s: expected %0h actual %0h", name, exp, act);
  endtask

  // Busy entry with the same ID first, else lowest free entry, -1 when none fits
  function automatic int predict_idx(input logic [idr_pkg::ID_UP_W-1:0] id);
    int free_idx;
    free_idx = -1;
    for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
      if (model_cnt[i] > 0 && model_id[i] == id) begin
        return (model_cnt[i] < idr_pkg::CNT_MAX) ? i : -1;
      end
      if (model_cnt[i] == 0 && free_idx < 0) begin
        free_idx = i;
      end
    end
    return free_idx;
  endfunction

  // ---------------------------------------------------------------------
  // Downstream responder
  // ---------------------------------------------------------------------
  task automatic return_burst(input int p);
    idr_pkg::r_dn_t beat;
    idr_pkg::r_up_t exp_up;
    logic [127:0]   bits;
    logic [1:0]     exp_vr;
    string          name;
    int             idx;
    int             len;
    idx = pend_idx[p];
    len = pend_len[p];
    for (int b = 0; b <= len; b++) begin
      draw_bits(128, bits);
      beat.data = bits;
      draw_bits(2, bits);
      beat.resp = bits[1:0];
      beat.id   = idr_pkg::ID_DN_W'(idx);
      beat.last = (b == len);
      exp_up    = '{model_id[idx], beat.data, beat.resp, beat.last};
      exp_vr    = beat.last ? 2'b10 : 2'b11;
      name      = $sformatf("r_up idx %0d beat %0d", idx, b);
      @(posedge clk_i);
      r_dn_i       <= beat;
      r_dn_valid_i <= 1'b1;
      r_up_ready_i <= !beat.last;  // Last beat waits one cycle upstream
      @(negedge clk_i);
      if ({r_up_valid_o, r_dn_ready_o} !== exp_vr) begin
        report_mismatch({name, " valid/ready"}, 160'(exp_vr),
                        160'({r_up_valid_o, r_dn_ready_o}));
      end
      if (r_up_o !== exp_up) begin
        report_mismatch(name, 160'(exp_up), 160'(r_up_o));
      end
    end
    @(posedge clk_i);
    r_up_ready_i <= 1'b1;
    @(negedge clk_i);
    if (r_dn_ready_o !== 1'b1) begin
      report_mismatch({name, " ready"}, 160'(1), 160'(r_dn_ready_o));
    end
    @(posedge clk_i);  // Last beat transfers here
    r_dn_valid_i <= 1'b0;
    model_cnt[idx] = model_cnt[idx] - 1;
    pend_idx.delete(p);
    pend_len.delete(p);
    burst_cnt++;
  endtask

  // ---------------------------------------------------------------------
  // Request driver
  // ---------------------------------------------------------------------
  task automatic send_row(input int r);
    idr_pkg::ar_up_t req;
    idr_pkg::ar_dn_t exp_dn;
    string           name;
    int              idx;
    int              p;
    req   = '{rows[r].id, rows[r].addr, rows[r].len, 3'(r % 5),
              idr_pkg::burst_e'(2'(r % 3)), 3'b101, rows[r].user};
    name  = $sformatf("row %0d ar_dn", r);
    @(posedge clk_i);
    ar_up_i       <= req;
    ar_up_valid_i <= 1'b1;
    idx = predict_idx(req.id);
    if (idx < 0) begin
      repeat (HOLD_CYC) begin
        @(negedge clk_i);
        if (ar_up_ready_o !== 1'b0) begin
          report_mismatch($sformatf("row %0d ready, table full", r), 160'(0),
                          160'(ar_up_ready_o));
        end
      end
      p = 0;
      while (model_cnt[pend_idx[p]] != 1) begin
        p++;
      end
      return_burst(p);  // Frees one entry
      idx = predict_idx(req.id);
    end
    @(negedge clk_i);
    while (ar_up_ready_o !== 1'b1) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ar_up_valid_i <= 1'b0;
    ar_dn_ready_i <= !rows[r].hold;
    model_id[idx]  = req.id;
    model_cnt[idx] = model_cnt[idx] + 1;
    pend_idx.push_back(idx);
    pend_len.push_back(int'(req.len));
    exp_dn = '{idr_pkg::ID_DN_W'(idx), req.addr[idr_pkg::ADDR_DN_W-1:0], req.len,
               req.size, req.burst, idr_pkg::PROT_FIXED, req.user[0]};
    for (int c = 0; c <= (rows[r].hold ? HOLD_CYC : 0); c++) begin
      @(negedge clk_i);
      if (ar_dn_valid_o !== 1'b1) begin
        report_mismatch({name, " valid"}, 160'(1), 160'(ar_dn_valid_o));
      end
      if (ar_dn_o !== exp_dn) begin
        report_mismatch(name, 160'(exp_dn), 160'(ar_dn_o));
      end
      if (rows[r].hold && ar_up_ready_o !== 1'b0) begin
        report_mismatch({name, " stalled ready"}, 160'(0), 160'(ar_up_ready_o));
      end
    end
    if (rows[r].hold) begin
      @(posedge clk_i);
      ar_dn_ready_i <= 1'b1;
    end
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    lfsr_q        = 16'd63;
    rst_n_i       <= 1'b0;
    ar_up_i       <= '0;
    ar_up_valid_i <= 1'b0;
    r_up_ready_i  <= 1'b1;
    ar_dn_ready_i <= 1'b1;
    r_dn_i        <= '0;
    r_dn_valid_i  <= 1'b0;
    for (int i = 0; i < idr_pkg::TABLE_SIZE; i++) begin
      model_cnt[i] = 0;
    end
    load_rows();
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    if (ar_dn_valid_o !== 1'b0) begin
      report_mismatch("ar_dn_valid after reset", 160'(0), 160'(ar_dn_valid_o));
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_row(r);
    end
    while (pend_idx.size() > 0) begin
      return_burst(0);
    end
    repeat (2) @(posedge clk_i);
    assert_cnt = DUT.u_assert.fail_cnt;
    $display("Rows: %0d, bursts: %0d, check errors: %0d, assertion failures: %0d",
             NUM_ROWS, burst_cnt, err_cnt, assert_cnt);
    if (err_cnt == 0 && assert_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/idr_pkg.sv
logic/id_remap_table.sv
logic/ar_slice.sv
logic/axi_rd_id_remap.sv
sim/axi_rd_id_remap_assert.sv
sim/tb_axi_rd_id_remap.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_axi_rd_id_remap \
  -f tb.f \
  -o tb_sim

./obj_dir/tb_sim +verilator+error+limit+100 | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
echo "Simulation finished without failures"
